/* dv/executeStage_assert.sv */
////////////////////
// Bound checks on the execute stage valid and PC behavior.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeStage_assert
   import execPkg::*;
#(
   parameter int width = wordWidth
) (
   input wire logic             clk,
   input wire logic             rstN,
   input wire logic             inValid,
   input wire logic             aluJump,
   input wire logic [4:0]       opcode,
   input wire logic [2:0]       brType,
   input wire logic [width-1:0] pc,
   input wire logic             outValid,
   input wire logic [width-1:0] newPc
);

   // Output valid is the input qualifier one clock later.
   validFollows: assert property (@(posedge clk) disable iff (!rstN)
      outValid == $past(inValid))
      else $error("outValid does not follow inValid");

   resetLow: assert property (@(posedge clk) !rstN |-> !outValid)
      else $error("outValid high during reset");

   // No jump, no branch, so the next PC is the sequential one.
   pcHeld: assert property (@(posedge clk) disable iff (!rstN)
      (inValid && !aluJump && brType == brNone && opcode != opJ && opcode != opJal)
      |=> newPc == $past(pc))
      else $error("newPc differs from sequential pc");

endmodule

bind executeStage executeStage_assert #(.width(width)) checks_i (
   .clk      (clk),
   .rstN     (rstN),
   .inValid  (inValid),
   .aluJump  (aluJump),
   .opcode   (opcode),
   .brType   (brType),
   .pc       (pc),
   .outValid (outValid),
   .newPc    (newPc)
);

`default_nettype wire

/* dv/executeStage_tb.sv */
////////////////////
// Testbench for the execute stage.
// Table rows, then random ALU rows checked against a reference model.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeStage_tb
   import execPkg::*;
();

   localparam logic [4:0]  opAlu   = 5'b11011;    // Plain ALU instruction.
   localparam logic [4:0]  opJr    = 5'b00101;    // Register jump.
   localparam logic [15:0] pcSeq   = 16'h0100;    // Sequential PC.
   localparam logic [15:0] pcBr7   = 16'h0111;    // pcSeq plus inst7.
   localparam logic [15:0] pcBr10  = 16'h0300;    // pcSeq plus inst10.
   localparam logic [15:0] imm4    = 16'h0003;
   localparam logic [15:0] imm7    = 16'h0011;
   localparam logic [15:0] imm10   = 16'h0200;
   localparam logic [15:0] slbiVal = 16'h1234;
   localparam int          timeoutCycles = 20;    // Max wait for outValid.

   // One instruction with its expected results.
   typedef struct packed {
      logic [4:0]  op;
      logic [2:0]  oper;
      logic [1:0]  bSrc;
      logic [3:0]  ctl;                           // invA, invB, cin, sign.
      logic [2:0]  br;
      logic [1:0]  jmp;                           // immSrc, aluJump.
      logic [15:0] a;
      logic [15:0] b;                             // Drives regData.
      logic [15:0] expX;
      logic [15:0] expPc;
   } rowT;

   logic        clk;
   logic        rstN;
   logic        inValid;
   logic        invA, invB, cin, sign, immSrc, aluJump;
   logic [4:0]  opcode;
   logic [2:0]  oper;
   logic [2:0]  brType;
   logic [1:0]  bSrc;
   logic [15:0] pc, a, regData, inst4, inst7, inst10, slbi;
   logic        outValid;
   logic [15:0] xComp;
   logic [15:0] newPc;

   int          seed;
   int          errCount;                         // Mismatches and timeouts.
   int          failCount;                        // Failed tests.
   int          testCount;
   logic        testFail;                         // Current test has failed.
   logic [15:0] lastX;                            // Last result, held over bubbles.
   rowT         rows[$];

   executeStage #(.width(wordWidth)) dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;                     // 40 ns period.
   end

   ////////////////////
   // Reference model
   ////////////////////
   function automatic logic [15:0] refAlu(input logic [15:0] aIn, input logic [15:0] bIn,
                                          input logic [2:0] op, input logic [3:0] ctl);
      logic [15:0] x;
      logic [15:0] y;
      logic [4:0]  n;
      x = ctl[3] ? ~aIn : aIn;                    // Optional inversions.
      y = ctl[2] ? ~bIn : bIn;
      n = {1'b0, y[3:0]};                         // Count is the low nibble of B.
      case (op)
         aluRll:  return (x << n) | (x >> (5'd16 - n));
         aluSll:  return x << n;
         aluRor:  return (x >> n) | (x << (5'd16 - n));
         aluSrl:  return x >> n;
         aluAdd:  return x + y + {15'd0, ctl[1]};
         aluAnd:  return x & y;
         aluOr:   return x | y;
         default: return x ^ y;
      endcase
   endfunction

   task automatic checkVal(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         errCount++;
         testFail = 1'b1;
      end
   endtask

   task automatic finishTest(input string tag);
      testCount++;
      if (testFail) begin
         failCount++;
         $display("%s: FAIL", tag);
      end else begin
         $display("%s: ok", tag);
      end
      testFail = 1'b0;
   endtask

   // Drive one row at a falling edge and check it once outValid shows up.
   task automatic runRow(input rowT r);
      int cycles;
      inValid = 1'b1;
      opcode  = r.op;
      oper    = r.oper;
      bSrc    = r.bSrc;
      brType  = r.br;
      a       = r.a;
      regData = r.b;
      {invA, invB, cin, sign} = r.ctl;
      {immSrc, aluJump} = r.jmp;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!outValid && cycles < timeoutCycles);
      if (!outValid) begin
         $display("Timeout, outValid did not rise within %0d cycles", timeoutCycles);
         errCount++;
         testFail = 1'b1;
      end
      checkVal("latency", 16'(cycles), 16'h0001);   // Exactly one clock.
      checkVal("xComp", xComp, r.expX);
      checkVal("newPc", newPc, r.expPc);
      lastX = r.expX;
   endtask

   ////////////////////
   // Stimulus table
   ////////////////////
   task automatic fillTable();
      // ALU ops with each B source, newPc stays at pc.
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brNone, 2'b00, 16'h1234, 16'h1111, 16'h2345, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h1234, 16'h0234, 16'h1000, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b1011, brNone, 2'b00, 16'h0001, 16'h0005, 16'h0004, pcSeq});
      rows.push_back({opAlu, aluAnd, bInst4, 4'b0001, brNone, 2'b00, 16'h00FF, 16'hDEAD, 16'h0003, pcSeq});
      rows.push_back({opAlu, aluOr, bInst7, 4'b0001, brNone, 2'b00, 16'h0F00, 16'hDEAD, 16'h0F11, pcSeq});
      rows.push_back({opAlu, aluXor, bSlbi, 4'b0001, brNone, 2'b00, 16'hFFFF, 16'hDEAD, 16'hEDCB, pcSeq});
      rows.push_back({opAlu, aluRll, bInst4, 4'b0001, brNone, 2'b00, 16'h8001, 16'hDEAD, 16'h000C, pcSeq});
      rows.push_back({opAlu, aluSll, bReg, 4'b0001, brNone, 2'b00, 16'h1234, 16'h0004, 16'h2340, pcSeq});
      rows.push_back({opAlu, aluRor, bInst4, 4'b0001, brNone, 2'b00, 16'h0009, 16'hDEAD, 16'h2001, pcSeq});
      rows.push_back({opAlu, aluSrl, bReg, 4'b0001, brNone, 2'b00, 16'hABCD, 16'h0008, 16'h00AB, pcSeq});
      // Set instructions, A-B except SCO, with overflow corners.
      rows.push_back({opSeq, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h1234, 16'h1234, 16'h0001, pcSeq});
      rows.push_back({opSeq, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h1234, 16'h1235, 16'h0000, pcSeq});
      rows.push_back({opSlt, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h8000, 16'h0001, 16'h0001, pcSeq});
      rows.push_back({opSlt, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h7FFF, 16'hFFFF, 16'h0000, pcSeq});
      rows.push_back({opSle, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h0005, 16'h0005, 16'h0001, pcSeq});
      rows.push_back({opSle, aluAdd, bReg, 4'b0111, brNone, 2'b00, 16'h0006, 16'h0005, 16'h0000, pcSeq});
      rows.push_back({opSco, aluAdd, bReg, 4'b0001, brNone, 2'b00, 16'hFFFF, 16'h0001, 16'h0001, pcSeq});
      rows.push_back({opSco, aluAdd, bReg, 4'b0001, brNone, 2'b00, 16'h7FFF, 16'h0001, 16'h0000, pcSeq});
      // Branches, B forced to zero so xComp is A.
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brEqz, 2'b00, 16'h0000, 16'hDEAD, 16'h0000, pcBr7});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brEqz, 2'b10, 16'h0005, 16'hDEAD, 16'h0005, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brEqz, 2'b00, 16'hFFF0, 16'hDEAD, 16'hFFF0, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brNez, 2'b10, 16'h0005, 16'hDEAD, 16'h0005, pcBr10});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brNez, 2'b00, 16'h0000, 16'hDEAD, 16'h0000, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brNez, 2'b00, 16'h8000, 16'hDEAD, 16'h8000, pcBr7});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brLtz, 2'b00, 16'h8003, 16'hDEAD, 16'h8003, pcBr7});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brLtz, 2'b10, 16'h0007, 16'hDEAD, 16'h0007, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brLtz, 2'b00, 16'h0000, 16'hDEAD, 16'h0000, pcSeq});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brGez, 2'b10, 16'h0000, 16'hDEAD, 16'h0000, pcBr10});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brGez, 2'b00, 16'h0042, 16'hDEAD, 16'h0042, pcBr7});
      rows.push_back({opAlu, aluAdd, bReg, 4'b0001, brGez, 2'b00, 16'hFFFF, 16'hDEAD, 16'hFFFF, pcSeq});
      // Direct jumps, then register jumps through the ALU.
      rows.push_back({opJ, aluAdd, bReg, 4'b0001, brNone, 2'b10, 16'h0000, 16'h0000, 16'h0000, pcBr10});
      rows.push_back({opJal, aluAdd, bReg, 4'b0001, brNone, 2'b10, 16'h0102, 16'h0000, 16'h0102, pcBr10});
      rows.push_back({opJr, aluAdd, bInst7, 4'b0001, brNone, 2'b01, 16'h0400, 16'hDEAD, 16'h0411, 16'h0411});
   endtask

   ////////////////////
   // Test sequence
   ////////////////////
   initial begin
      rowT         r;
      logic [31:0] rnd;
      logic [15:0] bVal;
      seed      = 74047;
      errCount  = 0;
      failCount = 0;
      testCount = 0;
      testFail  = 1'b0;
      lastX     = '0;
      rstN      = 1'b1;
      inValid   = 1'b0;
      opcode    = '0;
      oper      = '0;
      bSrc      = '0;
      brType    = '0;
      {invA, invB, cin, sign, immSrc, aluJump} = 6'b0;
      a         = '0;
      regData   = '0;
      pc        = pcSeq;                          // Fixed PC and immediates.
      inst4     = imm4;
      inst7     = imm7;
      inst10    = imm10;
      slbi      = slbiVal;
      #1 rstN = 1'b0;
      repeat (2) @(negedge clk);                  // Two cycles in reset.
      rstN = 1'b1;
      checkVal("outValid", {15'd0, outValid}, 16'h0000);
      checkVal("xComp", xComp, 16'h0000);
      checkVal("newPc", newPc, 16'h0000);
      finishTest("reset");

      fillTable();
      foreach (rows[i]) begin                     // Back to back, one per cycle.
         runRow(rows[i]);
         finishTest($sformatf("row %0d", i));
      end

      for (int i = 0; i < 48; i++) begin
         rnd    = $random(seed);
         r.a    = rnd[15:0];
         r.oper = rnd[18:16];
         r.bSrc = rnd[20:19];
         r.ctl  = rnd[24:21];
         rnd    = $random(seed);
         r.b    = rnd[15:0];
         r.op   = opAlu;
         r.br   = brNone;
         r.jmp  = 2'b00;
         case (r.bSrc)                            // Operand the ALU should see.
            bReg:    bVal = r.b;
            bInst4:  bVal = imm4;
            bInst7:  bVal = imm7;
            default: bVal = slbiVal;
         endcase
         r.expX  = refAlu(r.a, bVal, r.oper, r.ctl);
         r.expPc = pcSeq;
         runRow(r);
         finishTest($sformatf("rand %0d", i));
      end

      // Two bubbles, then a fresh instruction.
      // Live inputs under the bubbles ask for a new result and a jump target.
      inValid = 1'b0;
      opcode  = opJ;
      immSrc  = 1'b1;
      aluJump = 1'b0;
      brType  = brNone;
      oper    = aluXor;
      bSrc    = bReg;
      {invA, invB, cin} = 3'b000;
      a       = ~lastX;
      regData = '0;
      repeat (2) begin
         @(negedge clk);
         checkVal("outValid", {15'd0, outValid}, 16'h0000);
         checkVal("xComp", xComp, lastX);         // Held over the gap.
         checkVal("newPc", newPc, pcSeq);
      end
      runRow(rows[0]);
      finishTest("gap");

      $display("tests %0d failed %0d mismatches %0d", testCount, failCount, errCount);
      if (failCount == 0 && errCount == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* execute16.f */
hw/execPkg.sv
hw/aluFlagsIf.sv
hw/execAlu.sv
hw/branchTarget.sv
hw/exCombine.sv
hw/executeStage.sv
dv/executeStage_assert.sv
dv/executeStage_tb.sv

/* hw/aluFlagsIf.sv */
////////////////////
// ALU result and flags, ALU to combiner.
////////////////////
`timescale 1ns/1ns
`default_nettype none

interface aluFlagsIf
   import execPkg::*;
#(
   parameter int width = wordWidth
);

   logic [width-1:0] result;                      // ALU output.
   logic             zero;                        // Result is all zeros.
   logic             sign;                        // Top bit of result.
   logic             ofl;                         // Overflow of the add.
   logic             carry;                       // Carry out of the add.

   modport src (output result, zero, sign, ofl, carry);
   modport dst (input  result, zero, sign, ofl, carry);

endinterface

`default_nettype wire

/* hw/branchTarget.sv */
////////////////////
// Branch target adder.
// Carry-lookahead sum of PC and the chosen displacement.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module branchTarget
   import execPkg::*;
#(
   parameter int width = wordWidth
) (
   input  wire logic [width-1:0] pc,              // Sequential PC.
   input  wire logic [width-1:0] inst7,           // Short displacement.
   input  wire logic [width-1:0] inst10,          // Long displacement.
   input  wire logic             immSrc,          // Pick the long displacement.
   output logic      [width-1:0] target           // PC plus displacement.
);

   localparam int nGrp = (width + 3) / 4;         // Number of 4-bit groups.
   localparam int padW = 4 * nGrp;                // Width rounded up to groups.

   logic [width-1:0] disp;                        // Selected displacement.
   logic [padW-1:0]  opA;                         // Padded PC.
   logic [padW-1:0]  opB;                         // Padded displacement.
   logic [padW-1:0]  g;                           // Bit generate.
   logic [padW-1:0]  p;                           // Bit propagate.
   logic [padW-1:0]  sum;
   logic [nGrp-1:0]  gc;                          // Carry into each group.

   assign disp = immSrc ? inst10 : inst7;
   assign opA  = padW'(pc);
   assign opB  = padW'(disp);
   assign g    = opA & opB;
   assign p    = opA ^ opB;
   assign gc[0] = 1'b0;                           // No carry in.

   ////////////////////
   // Lookahead groups
   ////////////////////
   for (genvar k = 0; k < nGrp; k++) begin : grp
      logic [3:0] gg;                             // Group slice of g.
      logic [3:0] pp;                             // Group slice of p.
      logic [3:0] c;                              // Carry into each bit.

      assign gg   = g[4*k +: 4];
      assign pp   = p[4*k +: 4];
      assign c[0] = gc[k];
      assign c[1] = gg[0] | (pp[0] & c[0]);
      assign c[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & c[0]);
      assign c[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                  | (pp[2] & pp[1] & pp[0] & c[0]);
      assign sum[4*k +: 4] = pp ^ c;

      // Group generate/propagate feed the next group, the carry out of the top is dropped.
      if (k < nGrp - 1) begin : link
         logic grpG;
         logic grpP;

         assign grpG = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                     | (pp[3] & pp[2] & pp[1] & gg[0]);
         assign grpP = &pp;
         assign gc[k+1] = grpG | (grpP & c[0]);
      end
   end

   assign target = sum[width-1:0];                // Wraps like the PC.

endmodule

`default_nettype wire

/* hw/exCombine.sv */
////////////////////
// Execute result combiner and output register.
// Set conditions, branch decision, next-PC select.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module exCombine
   import execPkg::*;
#(
   parameter int width = wordWidth
) (
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire logic             inValid,         // Instruction present this cycle.
   input  wire logic [4:0]       opcode,
   input  wire logic [2:0]       brType,
   input  wire logic             aluJump,         // Register jump through the ALU.
   input  wire logic [width-1:0] pc,              // Sequential PC.
   input  wire logic [width-1:0] target,          // Branch target from the adder.
   aluFlagsIf.dst                flags,           // ALU result and flags.
   output logic                  outValid,        // Registered result is valid.
   output logic      [width-1:0] xComp,           // Stage result.
   output logic      [width-1:0] newPc            // Next program counter.
);

   logic [width-1:0] resNext;                     // Result before the register.
   logic [width-1:0] pcNext;                      // Next PC before the register.
   logic             less;                        // Signed A < B from A-B.
   logic             taken;                       // Conditional branch taken.

   ////////////////////
   // Set instructions
   ////////////////////
   assign less = flags.sign ^ flags.ofl;

   always_comb begin
      unique case (opcode)
         opSeq:   resNext = width'(flags.zero);
         opSlt:   resNext = width'(less);
         opSle:   resNext = width'(less | flags.zero);
         opSco:   resNext = width'(flags.carry);   // Needs a plain A+B.
         default: resNext = flags.result;
      endcase
   end

   ////////////////////
   // Branch decision
   ////////////////////
   // B was forced to zero, so the flags describe A itself.
   always_comb begin
      unique case (brType)
         brEqz:   taken = flags.zero;
         brNez:   taken = ~flags.zero;
         brLtz:   taken = flags.sign;
         brGez:   taken = ~flags.sign;
         default: taken = 1'b0;                   // brNone and unused codes.
      endcase
   end

   always_comb begin
      if (aluJump) begin
         pcNext = flags.result;                   // JR / JALR style.
      end else if (taken || isJump(opcode)) begin
         pcNext = target;
      end else begin
         pcNext = pc;
      end
   end

   ////////////////////
   // Output register
   ////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outValid <= 1'b0;
         xComp    <= '0;
         newPc    <= '0;
      end else begin
         outValid <= inValid;
         if (inValid) begin                       // Hold values over bubbles.
            xComp <= resNext;
            newPc <= pcNext;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/execAlu.sv */
////////////////////
// Execute ALU with B-operand select.
// Shifts, rotates, add and logic ops, plus zero/sign/carry/overflow flags.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module execAlu
   import execPkg::*;
#(
   parameter int width = wordWidth
) (
   input  wire logic [width-1:0] a,               // Register operand A.
   input  wire logic [width-1:0] regData,         // Register operand B.
   input  wire logic [width-1:0] inst4,           // Short immediate.
   input  wire logic [width-1:0] inst7,           // Long immediate.
   input  wire logic [width-1:0] slbi,            // SLBI operand.
   input  wire logic [2:0]       oper,            // ALU operation.
   input  wire logic [1:0]       bSrc,            // B source select.
   input  wire logic [2:0]       brType,          // Branch type.
   input  wire logic             invA,            // Invert A.
   input  wire logic             invB,            // Invert B.
   input  wire logic             cin,             // Carry into the adder.
   input  wire logic             sign,            // Signed overflow select.
   aluFlagsIf.src                flags            // Result and flags out.
);

   localparam int shW = (width > 1) ? $clog2(width) : 1;   // Shift amount bits.

   logic [width-1:0]   bSel;                      // Selected B before inversion.
   logic [width-1:0]   opA;                       // A after optional inversion.
   logic [width-1:0]   opB;                       // B after optional inversion.
   logic [shW-1:0]     amt;                       // Shift and rotate amount.
   logic [2*width-1:0] rotLeft;                   // Doubled operand shifted left.
   logic [2*width-1:0] rotRight;                  // Doubled operand shifted right.
   logic [width:0]     sum;                       // Adder output with carry.
   logic               sOfl;                      // Two's complement overflow.
   logic [width-1:0]   res;                       // Selected ALU result.

   ////////////////////
   // Operand select
   ////////////////////
   always_comb begin
      unique case (bSrc)
         bReg:    bSel = regData;
         bInst4:  bSel = inst4;
         bInst7:  bSel = inst7;
         default: bSel = slbi;                    // bSlbi.
      endcase
      // Conditional branch test A against zero, so B goes away.
      if (brType[2]) begin
         bSel = '0;
      end
   end

   assign opA = invA ? ~a : a;
   assign opB = invB ? ~bSel : bSel;
   assign amt = opB[shW-1:0];                     // Low bits of B give the count.

   ////////////////////
   // Datapath
   ////////////////////
   assign sum      = {1'b0, opA} + {1'b0, opB} + {{width{1'b0}}, cin};
   assign rotLeft  = {opA, opA} << amt;           // Upper half is A rotated left.
   assign rotRight = {opA, opA} >> amt;           // Lower half is A rotated right.

   // Same input signs but a different result sign.
   assign sOfl = (opA[width-1] == opB[width-1]) && (sum[width-1] != opA[width-1]);

   always_comb begin
      unique case (oper)
         aluRll:  res = rotLeft[2*width-1:width];
         aluSll:  res = opA << amt;
         aluRor:  res = rotRight[width-1:0];
         aluSrl:  res = opA >> amt;
         aluAdd:  res = sum[width-1:0];
         aluAnd:  res = opA & opB;
         aluOr:   res = opA | opB;
         default: res = opA ^ opB;                // aluXor.
      endcase
   end

   ////////////////////
   // Flags
   ////////////////////
   assign flags.result = res;
   assign flags.zero   = ~|res;                   // All zeros.
   assign flags.sign   = res[width-1];            // Sign of the result.
   assign flags.carry  = sum[width];              // Adder carry out.
   assign flags.ofl    = sign ? sOfl : sum[width];   // Unsigned overflow is the carry.

endmodule

`default_nettype wire

/* hw/execPkg.sv */
////////////////////
// Shared definitions for the execute stage.
// Word width, opcodes, branch types, ALU ops and B sources.
////////////////////
`default_nettype none

package execPkg;

   localparam int wordWidth = 16;                 // Data and address width.

   ////////////////////
   // Opcodes
   ////////////////////
   localparam logic [4:0] opSeq = 5'b11100;       // Set if equal.
   localparam logic [4:0] opSlt = 5'b11101;       // Set if less than.
   localparam logic [4:0] opSle = 5'b11110;       // Set if less or equal.
   localparam logic [4:0] opSco = 5'b11111;       // Set on carry out.
   localparam logic [4:0] opJ   = 5'b00100;       // Direct jump.
   localparam logic [4:0] opJal = 5'b00110;       // Direct jump and link.

   ////////////////////
   // Branch types
   ////////////////////
   // Bit 2 marks a conditional branch.
   localparam logic [2:0] brNone = 3'b000;        // Not a branch.
   localparam logic [2:0] brEqz  = 3'b100;        // Taken when A is zero.
   localparam logic [2:0] brNez  = 3'b101;        // Taken when A is not zero.
   localparam logic [2:0] brLtz  = 3'b110;        // Taken when A is negative.
   localparam logic [2:0] brGez  = 3'b111;        // Taken when A is not negative.

   ////////////////////
   // ALU operations
   ////////////////////
   localparam logic [2:0] aluRll = 3'b000;        // Rotate left.
   localparam logic [2:0] aluSll = 3'b001;        // Shift left.
   localparam logic [2:0] aluRor = 3'b010;        // Rotate right.
   localparam logic [2:0] aluSrl = 3'b011;        // Shift right logical.
   localparam logic [2:0] aluAdd = 3'b100;        // Add with carry-in.
   localparam logic [2:0] aluAnd = 3'b101;
   localparam logic [2:0] aluOr  = 3'b110;
   localparam logic [2:0] aluXor = 3'b111;

   // B operand sources.
   localparam logic [1:0] bReg   = 2'b00;         // Second register read port.
   localparam logic [1:0] bInst4 = 2'b01;         // Short immediate.
   localparam logic [1:0] bInst7 = 2'b10;         // Long immediate.
   localparam logic [1:0] bSlbi  = 2'b11;         // Shift-and-load-byte operand.

   // J and JAL differ only in bit 1, the link bit.
   function automatic logic isJump(input logic [4:0] op);
      return (op == opJ) || (op == opJal);
   endfunction

endpackage

`default_nettype wire

/* hw/executeStage.sv */
////////////////////
// Execute stage top level.
// ALU and branch adder in parallel, merged and registered by the combiner.
////////////////////
`timescale 1ns/1ns
`default_nettype none

module executeStage
   import execPkg::*;
#(
   parameter int width = wordWidth
) (
   input  wire logic             clk,
   input  wire logic             rstN,
   input  wire logic             inValid,         // Instruction present.
   input  wire logic [4:0]       opcode,
   input  wire logic [width-1:0] pc,              // Sequential PC.
   input  wire logic [2:0]       oper,            // ALU operation.
   input  wire logic [width-1:0] a,               // Operand A.
   input  wire logic [width-1:0] regData,         // Register B source.
   input  wire logic [width-1:0] inst4,
   input  wire logic [width-1:0] inst7,
   input  wire logic [width-1:0] inst10,
   input  wire logic [width-1:0] slbi,
   input  wire logic [1:0]       bSrc,            // B source select.
   input  wire logic             invA,
   input  wire logic             invB,
   input  wire logic             cin,
   input  wire logic             sign,            // Signed overflow.
   input  wire logic             immSrc,          // Long branch displacement.
   input  wire logic             aluJump,         // Next PC from the ALU.
   input  wire logic [2:0]       brType,
   output logic                  outValid,
   output logic      [width-1:0] xComp,           // Stage result.
   output logic      [width-1:0] newPc            // Next PC.
);

   aluFlagsIf #(.width(width)) flagsBus ();       // ALU to combiner.

   logic [width-1:0] target;                      // Branch target.

   ////////////////////
   // ALU
   ////////////////////
   execAlu #(.width(width)) alu_i (
      .a       (a),
      .regData (regData),
      .inst4   (inst4),
      .inst7   (inst7),
      .slbi    (slbi),
      .oper    (oper),
      .bSrc    (bSrc),
      .brType  (brType),
      .invA    (invA),
      .invB    (invB),
      .cin     (cin),
      .sign    (sign),
      .flags   (flagsBus.src)
   );

   // Branch target adder, runs beside the ALU.
   branchTarget #(.width(width)) target_i (
      .pc      (pc),
      .inst7   (inst7),
      .inst10  (inst10),
      .immSrc  (immSrc),
      .target  (target)
   );

   ////////////////////
   // Combiner
   ////////////////////
   exCombine #(.width(width)) combine_i (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .opcode   (opcode),
      .brType   (brType),
      .aluJump  (aluJump),
      .pc       (pc),
      .target   (target),
      .flags    (flagsBus.dst),
      .outValid (outValid),
      .xComp    (xComp),
      .newPc    (newPc)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module executeStage_tb \
   -f execute16.f

out=$(./obj_dir/VexecuteStage_tb)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
